//--- include/fp_fma_macros.svh
// --------------------------------------------------
// Shared constants for the binary64 FMA pipeline.
// Include wherever a width, the bias or the NaN word is needed.
// --------------------------------------------------
`ifndef FP_FMA_MACROS_SVH
`define FP_FMA_MACROS_SVH

// Register stages from operand capture to result
`define FP_FMA_STAGES 4

// binary64 field widths
`define FP_EXP_W  11
`define FP_MANT_W 52

// Exponent bias
`define FP_EXP_BIAS 1023

// Every NaN result uses this one quiet pattern
`define FP_QNAN 64'h7FF8000000000001

`endif

//--- hw/fp_fma_pkg.sv
// --------------------------------------------------
// Types shared by the FMA stages: operand word, class
// flags, operation mode and the inter-stage records.
// --------------------------------------------------
`include "fp_fma_macros.svh"

package fp_fma_pkg;

    // One binary64 word
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_MANT_W-1:0] frac;
    } fp64_t;

    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic is_zero;
    } fp_class_t;

    typedef struct packed {
        logic neg_product;
        logic neg_addend;
    } fma_mode_t;

    // --------------------------------------------------
    // Stage records
    // --------------------------------------------------
    // Exponents carry two extra bits so large products cannot wrap
    typedef struct packed {
        logic                        valid;
        logic                        p_sign;
        logic signed [`FP_EXP_W+1:0] p_exp;
        logic [`FP_MANT_W:0]         mant_a;
        logic [`FP_MANT_W:0]         mant_b;
        logic                        c_sign;
        logic [`FP_EXP_W-1:0]        c_exp;
        logic [`FP_MANT_W:0]         c_mant;
        fp_class_t                   cls_a;
        fp_class_t                   cls_b;
        fp_class_t                   cls_c;
    } s1_rec_t;

    typedef struct packed {
        logic                        valid;
        logic                        p_sign;
        logic signed [`FP_EXP_W+1:0] p_exp;
        logic [2*`FP_MANT_W+1:0]     p_mant;
        logic                        c_sign;
        logic [`FP_EXP_W-1:0]        c_exp;
        logic [`FP_MANT_W:0]         c_mant;
        logic                        p_nan;
        logic                        p_inf;
        logic                        p_zero;
        fp_class_t                   cls_c;
    } s2_rec_t;

    // Sum bus holds the binary point just below bit 210
    typedef struct packed {
        logic                        valid;
        logic                        sign;
        logic signed [`FP_EXP_W+1:0] exp;
        logic [4*`FP_MANT_W+3:0]     sum;
        logic                        special;
        fp64_t                       special_res;
        logic                        invalid;
    } s3_rec_t;

endpackage

//--- hw/fma_op_regs.sv
// --------------------------------------------------
// Operation register block for the FMA unit. Holds the
// mode written over the config port and the sticky flags.
// --------------------------------------------------
module fma_op_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_we,
    input  logic [3:0]            cfg_wdata,
    input  logic                  invalid_pulse,
    input  logic                  overflow_pulse,
    output fp_fma_pkg::fma_mode_t mode,
    output logic                  flag_invalid,
    output logic                  flag_overflow
);

    // Bit 0 negates the product and bit 1 the addend
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= '0;
        end else if (cfg_we) begin
            mode.neg_product <= cfg_wdata[0];
            mode.neg_addend  <= cfg_wdata[1];
        end
    end

    // Sticky flags where a pulse beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_invalid  <= 1'b0;
            flag_overflow <= 1'b0;
        end else begin
            if (invalid_pulse) begin
                flag_invalid <= 1'b1;
            end else if (cfg_we && cfg_wdata[2]) begin
                flag_invalid <= 1'b0;
            end
            if (overflow_pulse) begin
                flag_overflow <= 1'b1;
            end else if (cfg_we && cfg_wdata[3]) begin
                flag_overflow <= 1'b0;
            end
        end
    end

    // Clear bits only come together with the write strobe
    a_clear_with_we: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_we |-> (cfg_wdata[3:2] == 2'b00));

endmodule

//--- hw/fp_classify.sv
// --------------------------------------------------
// FMA stage 1. Unpacks a, b and c, applies the mode's
// sign flips, classifies specials, sums product exponents.
// --------------------------------------------------
`include "fp_fma_macros.svh"

module fp_classify (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  fp_fma_pkg::fp64_t     a,
    input  fp_fma_pkg::fp64_t     b,
    input  fp_fma_pkg::fp64_t     c,
    input  fp_fma_pkg::fma_mode_t mode,
    output fp_fma_pkg::s1_rec_t   s1
);
    import fp_fma_pkg::*;

    logic signed [`FP_EXP_W+1:0] eff_exp_a;
    logic signed [`FP_EXP_W+1:0] eff_exp_b;
    s1_rec_t                     s1_next;

    function automatic fp_class_t classify(input fp64_t x);
        fp_class_t r;
        r.is_nan  = (x.exp == '1) && (x.frac != '0);
        r.is_inf  = (x.exp == '1) && (x.frac == '0);
        r.is_zero = (x.exp == '0) && (x.frac == '0);
        return r;
    endfunction

    // Denormals use exponent 1 with a zero hidden bit
    assign eff_exp_a = (a.exp == '0) ? 13'sd1 : $signed({2'b00, a.exp});
    assign eff_exp_b = (b.exp == '0) ? 13'sd1 : $signed({2'b00, b.exp});

    always_comb begin
        s1_next.valid  = in_valid;
        s1_next.p_sign = a.sign ^ b.sign ^ mode.neg_product;
        s1_next.p_exp  = eff_exp_a + eff_exp_b - 13'sd`FP_EXP_BIAS;
        s1_next.mant_a = {a.exp != '0, a.frac};
        s1_next.mant_b = {b.exp != '0, b.frac};
        // Addend keeps its raw exponent for pass-through
        s1_next.c_sign = c.sign ^ mode.neg_addend;
        s1_next.c_exp  = c.exp;
        s1_next.c_mant = {c.exp != '0, c.frac};
        s1_next.cls_a  = classify(a);
        s1_next.cls_b  = classify(b);
        s1_next.cls_c  = classify(c);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1 <= '0;
        end else begin
            s1 <= s1_next;
        end
    end

endmodule

//--- hw/fp_mul_norm.sv
// --------------------------------------------------
// FMA stage 2. Multiplies the mantissas, normalizes the
// product to one integer bit and resolves its specials.
// --------------------------------------------------
`include "fp_fma_macros.svh"

module fp_mul_norm (
    input  logic                clk,
    input  logic                rst_n,
    input  fp_fma_pkg::s1_rec_t s1,
    output fp_fma_pkg::s2_rec_t s2
);
    import fp_fma_pkg::*;

    localparam int PROD_W = 2 * (`FP_MANT_W + 1);

    logic [PROD_W-1:0] prod;
    s2_rec_t           s2_next;

    // Full 106-bit product, integer part in the top two bits
    assign prod = s1.mant_a * s1.mant_b;

    always_comb begin
        s2_next.valid  = s1.valid;
        s2_next.p_sign = s1.p_sign;

        // 1x.f form, move the point so bit 104 is the lead
        if (prod[PROD_W-1]) begin
            s2_next.p_mant = prod >> 1;
            s2_next.p_exp  = s1.p_exp + 13'sd1;
        end else begin
            s2_next.p_mant = prod;
            s2_next.p_exp  = s1.p_exp;
        end

        s2_next.c_sign = s1.c_sign;
        s2_next.c_exp  = s1.c_exp;
        s2_next.c_mant = s1.c_mant;
        s2_next.cls_c  = s1.cls_c;

        // Product specials, inf times zero is invalid
        s2_next.p_nan  = s1.cls_a.is_nan || s1.cls_b.is_nan
                      || (s1.cls_a.is_inf && s1.cls_b.is_zero)
                      || (s1.cls_a.is_zero && s1.cls_b.is_inf);
        s2_next.p_inf  = s1.cls_a.is_inf || s1.cls_b.is_inf;
        s2_next.p_zero = s1.cls_a.is_zero || s1.cls_b.is_zero;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2 <= '0;
        end else begin
            s2 <= s2_next;
        end
    end

endmodule

//--- hw/fp_align_add.sv
// --------------------------------------------------
// FMA stage 3. Picks special results, otherwise aligns
// product and addend on a wide bus and adds magnitudes.
// --------------------------------------------------
`include "fp_fma_macros.svh"

module fp_align_add (
    input  logic                clk,
    input  logic                rst_n,
    input  fp_fma_pkg::s2_rec_t s2,
    output fp_fma_pkg::s3_rec_t s3
);
    import fp_fma_pkg::*;

    localparam int BUS_W  = 4 * (`FP_MANT_W + 1);
    localparam int PROD_W = 2 * (`FP_MANT_W + 1);

    logic [BUS_W-1:0]            p_ext;
    logic [BUS_W-1:0]            c_ext;
    logic [BUS_W-1:0]            p_al;
    logic [BUS_W-1:0]            c_al;
    logic signed [`FP_EXP_W+1:0] c_eff;
    logic [`FP_EXP_W+1:0]        diff;
    logic                        p_big_exp;
    logic                        nan_case;
    s3_rec_t                     s3_next;

    // Both leading bits land on bit 210 with bit 211 as carry room
    assign p_ext = {s2.p_mant, {PROD_W{1'b0}}};
    assign c_ext = {1'b0, s2.c_mant, {(BUS_W-`FP_MANT_W-2){1'b0}}};

    assign c_eff     = (s2.c_exp == '0) ? 13'sd1 : $signed({2'b00, s2.c_exp});
    assign p_big_exp = (s2.p_exp >= c_eff);
    assign nan_case  = s2.p_nan || s2.cls_c.is_nan
                    || (s2.p_inf && s2.cls_c.is_inf && (s2.p_sign != s2.c_sign));

    // Shift the smaller-exponent term right and let oversize shifts fall to zero
    always_comb begin
        diff = p_big_exp ? 13'(s2.p_exp - c_eff) : 13'(c_eff - s2.p_exp);
        p_al = p_big_exp ? p_ext : (p_ext >> diff);
        c_al = p_big_exp ? (c_ext >> diff) : c_ext;
    end

    always_comb begin
        s3_next       = '0;
        s3_next.valid = s2.valid;

        if (nan_case) begin
            s3_next.special     = 1'b1;
            s3_next.special_res = `FP_QNAN;
            s3_next.invalid     = 1'b1;
        end else if (s2.p_inf) begin
            s3_next.special     = 1'b1;
            s3_next.special_res = {s2.p_sign, {`FP_EXP_W{1'b1}}, {`FP_MANT_W{1'b0}}};
        end else if (s2.cls_c.is_inf) begin
            s3_next.special     = 1'b1;
            s3_next.special_res = {s2.c_sign, {`FP_EXP_W{1'b1}}, {`FP_MANT_W{1'b0}}};
        end else if (s2.p_zero) begin
            // Addend as is since its sign already carries the mode flip
            s3_next.special     = 1'b1;
            s3_next.special_res = {s2.c_sign, s2.c_exp, s2.c_mant[`FP_MANT_W-1:0]};
        end else if (s2.cls_c.is_zero) begin
            s3_next.sign = s2.p_sign;
            s3_next.exp  = s2.p_exp;
            s3_next.sum  = p_ext;
        end else begin
            s3_next.exp = p_big_exp ? s2.p_exp : c_eff;
            if (s2.p_sign == s2.c_sign) begin
                s3_next.sign = s2.p_sign;
                s3_next.sum  = p_al + c_al;
            end else if (p_al >= c_al) begin
                // Ties go to the product sign so cancellation keeps it
                s3_next.sign = s2.p_sign;
                s3_next.sum  = p_al - c_al;
            end else begin
                s3_next.sign = s2.c_sign;
                s3_next.sum  = c_al - p_al;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s3 <= '0;
        end else begin
            s3 <= s3_next;
        end
    end

    // A special result carries no sum and invalid only comes with a special
    a_special_consistent: assert property (@(posedge clk) disable iff (!rst_n)
        s3.valid |-> (!(s3.special && (s3.sum != '0)) && !(s3.invalid && !s3.special)));

endmodule

//--- hw/fp_norm_pack.sv
// --------------------------------------------------
// FMA stage 4. Renormalizes the sum, truncates, handles
// overflow and denormals, packs the word, raises flag pulses.
// --------------------------------------------------
`include "fp_fma_macros.svh"

module fp_norm_pack (
    input  logic                clk,
    input  logic                rst_n,
    input  fp_fma_pkg::s3_rec_t s3,
    output fp_fma_pkg::fp64_t   result,
    output logic                out_valid,
    output logic                invalid_pulse,
    output logic                overflow_pulse
);
    import fp_fma_pkg::*;

    localparam int BUS_W = 4 * (`FP_MANT_W + 1);
    localparam int LEAD  = BUS_W - 2;
    localparam int FLO   = LEAD - `FP_MANT_W;

    logic [BUS_W-1:0]            mant;
    logic [LEAD:0]               dmant;
    logic signed [`FP_EXP_W+1:0] fexp;
    logic [`FP_EXP_W+1:0]        dshift;
    logic [7:0]                  lead;
    logic [7:0]                  shamt;
    logic [`FP_EXP_W-1:0]        out_exp;
    logic [`FP_MANT_W-1:0]       out_frac;
    logic                        ovf;
    fp64_t                       res_next;

    // Position of the highest set bit below the carry bit
    always_comb begin
        lead = '0;
        for (int i = 0; i <= LEAD; i++) begin
            if (s3.sum[i]) begin
                lead = 8'(i);
            end
        end
        shamt = 8'(LEAD) - lead;
    end

    always_comb begin
        mant   = s3.sum;
        fexp   = s3.exp;
        dshift = '0;
        dmant  = '0;
        ovf    = 1'b0;

        if (s3.sum[BUS_W-1]) begin
            mant = s3.sum >> 1;
            fexp = s3.exp + 13'sd1;
        end else if (!s3.sum[LEAD] && (s3.sum != '0)) begin
            mant = s3.sum << shamt;
            fexp = s3.exp - $signed({5'b00000, shamt});
        end

        // Truncate, the bits below the fraction are dropped
        out_frac = mant[LEAD-1:FLO];
        out_exp  = fexp[`FP_EXP_W-1:0];

        if (fexp >= 13'sd2047) begin
            out_exp  = '1;
            out_frac = '0;
            ovf      = !s3.special && (s3.sum != '0);
        end else if (fexp <= 13'sd0) begin
            // Denormal, shift the hidden one into the fraction
            dshift   = 13'(13'sd1 - fexp);
            dmant    = {1'b1, mant[LEAD-1:0]} >> dshift;
            out_frac = dmant[LEAD-1:FLO];
            out_exp  = '0;
        end

        if (s3.special) begin
            res_next = s3.special_res;
        end else if (s3.sum == '0) begin
            res_next = {s3.sign, {(`FP_EXP_W+`FP_MANT_W){1'b0}}};
        end else begin
            res_next = {s3.sign, out_exp, out_frac};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result         <= '0;
            out_valid      <= 1'b0;
            invalid_pulse  <= 1'b0;
            overflow_pulse <= 1'b0;
        end else begin
            result         <= res_next;
            out_valid      <= s3.valid;
            invalid_pulse  <= s3.valid && s3.invalid;
            overflow_pulse <= s3.valid && ovf;
        end
    end

endmodule

//--- hw/fp_fma_top.sv
// --------------------------------------------------
// Top of the binary64 FMA unit. Four stages in a row,
// steered by the operation register block.
// --------------------------------------------------
`include "fp_fma_macros.svh"

module fp_fma_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  fp_fma_pkg::fp64_t a,
    input  fp_fma_pkg::fp64_t b,
    input  fp_fma_pkg::fp64_t c,
    input  logic              cfg_we,
    input  logic [3:0]        cfg_wdata,
    output fp_fma_pkg::fp64_t result,
    output logic              out_valid,
    output logic              flag_invalid,
    output logic              flag_overflow
);
    import fp_fma_pkg::*;

    fma_mode_t mode;
    s1_rec_t   s1;
    s2_rec_t   s2;
    s3_rec_t   s3;
    logic      invalid_pulse;
    logic      overflow_pulse;

    fma_op_regs u_regs (
        .clk, .rst_n, .cfg_we, .cfg_wdata, .invalid_pulse, .overflow_pulse,
        .mode, .flag_invalid, .flag_overflow
    );

    fp_classify  u_s1 (.clk, .rst_n, .in_valid, .a, .b, .c, .mode, .s1);
    fp_mul_norm  u_s2 (.clk, .rst_n, .s1, .s2);
    fp_align_add u_s3 (.clk, .rst_n, .s2, .s3);

    fp_norm_pack u_s4 (
        .clk, .rst_n, .s3, .result, .out_valid, .invalid_pulse, .overflow_pulse
    );

    // Fixed latency, one result per accepted operation
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, `FP_FMA_STAGES));

endmodule

//--- testbench/fma_ref_pkg.sv
// --------------------------------------------------
// Reference model for the binary64 FMA testbench, plus
// the Galois LFSR step used for random stimulus.
// --------------------------------------------------
`include "fp_fma_macros.svh"

package fma_ref_pkg;

    // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // Signed integer value as a binary64 word
    function automatic logic [63:0] int_to_fp(input logic sign, input int unsigned mag);
        logic [63:0] bits;
        bits = $realtobits(real'(mag));
        return {sign, bits[62:0]};
    endfunction

    function automatic logic is_nan(input logic [63:0] x);
        return (x[62:52] == 11'h7FF) && (x[51:0] != 52'h0);
    endfunction

    function automatic logic is_inf(input logic [63:0] x);
        return (x[62:52] == 11'h7FF) && (x[51:0] == 52'h0);
    endfunction

    function automatic logic is_zero(input logic [63:0] x);
        return x[62:0] == 63'h0;
    endfunction

    // --------------------------------------------------
    // a * b + c with the mode's sign flips, exact for small integers
    // --------------------------------------------------
    function automatic logic [63:0] fma_model(
        input  logic [63:0] a,
        input  logic [63:0] b,
        input  logic [63:0] c,
        input  logic        neg_p,
        input  logic        neg_c,
        output logic        invalid,
        output logic        overflow
    );
        logic        ps;
        logic        cs;
        logic        p_inf;
        logic        p_zero;
        real         pm;
        real         cm;
        real         sum;
        logic [63:0] bits;
        invalid  = 1'b0;
        overflow = 1'b0;
        ps       = a[63] ^ b[63] ^ neg_p;
        cs       = c[63] ^ neg_c;
        p_inf    = is_inf(a) || is_inf(b);
        p_zero   = is_zero(a) || is_zero(b);
        if (is_nan(a) || is_nan(b) || is_nan(c) || (p_inf && p_zero)
                || (p_inf && is_inf(c) && (ps != cs))) begin
            invalid = 1'b1;
            return `FP_QNAN;
        end
        if (p_inf) begin
            return {ps, 11'h7FF, 52'h0};
        end
        if (is_inf(c)) begin
            return {cs, 11'h7FF, 52'h0};
        end
        // Zero product gives the addend, signed zero included
        if (p_zero) begin
            return {cs, c[62:0]};
        end
        pm  = $bitstoreal({1'b0, a[62:0]}) * $bitstoreal({1'b0, b[62:0]});
        cm  = $bitstoreal({1'b0, c[62:0]});
        sum = (ps ? -pm : pm) + (cs ? -cm : cm);
        if (sum == 0.0) begin
            return {ps, 63'h0};
        end
        bits = $realtobits(sum);
        if (bits[62:52] == 11'h7FF) begin
            overflow = 1'b1;
            return {bits[63], 11'h7FF, 52'h0};
        end
        return bits;
    endfunction

endpackage

//--- testbench/tb_fp_fma.sv
// --------------------------------------------------
// Testbench for the FMA unit. Random integer triples and
// directed specials, checked against the reference model.
// --------------------------------------------------
`include "fp_fma_macros.svh"

module tb_fp_fma;
    timeunit 1ns;
    timeprecision 1ps;

    import fp_fma_pkg::*;
    import fma_ref_pkg::*;

    localparam int          DRAIN_LIMIT = 20 * `FP_FMA_STAGES;
    localparam logic [63:0] POS_INF     = 64'h7FF0000000000000;
    localparam logic [63:0] NEG_INF     = 64'hFFF0000000000000;
    localparam logic [63:0] NAN_IN      = 64'h7FF4000000000000;
    localparam logic [63:0] ONE         = 64'h3FF0000000000000;
    localparam logic [63:0] TWO         = 64'h4000000000000000;
    localparam logic [63:0] NEG_ZERO    = 64'h8000000000000000;
    // 2^1000
    localparam logic [63:0] BIG         = 64'h7E70000000000000;

    typedef struct packed {
        logic [63:0] res;
        logic        invalid;
        logic        overflow;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    fp64_t       a;
    fp64_t       b;
    fp64_t       c;
    logic        cfg_we;
    logic [3:0]  cfg_wdata;
    fp64_t       result;
    logic        out_valid;
    logic        flag_invalid;
    logic        flag_overflow;

    logic [15:0] lfsr = 16'd59690;
    exp_t        exp_q[$];
    int          in_count = 0;
    int          out_count = 0;
    logic        model_inv = 1'b0;
    logic        model_ovf = 1'b0;
    logic [1:0]  cur_mode = 2'b00;
    string       test_name = "reset";

    fp_fma_top UUT (
        .clk, .rst_n, .in_valid, .a, .b, .c, .cfg_we, .cfg_wdata,
        .result, .out_valid, .flag_invalid, .flag_overflow
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopping on first error");
    endtask

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    // Drive one operation at a falling edge and queue its expected result
    task automatic send(input logic [63:0] x, input logic [63:0] y, input logic [63:0] z);
        exp_t e;
        logic inv;
        logic ovf;
        e.res      = fma_model(x, y, z, cur_mode[0], cur_mode[1], inv, ovf);
        e.invalid  = inv;
        e.overflow = ovf;
        exp_q.push_back(e);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        c        = z;
        in_count++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_random();
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] z;
        x = int_to_fp(1'(rand_bits(1)), rand_bits(20));
        y = int_to_fp(1'(rand_bits(1)), rand_bits(20));
        z = int_to_fp(1'(rand_bits(1)), rand_bits(20));
        send(x, y, z);
    endtask

    task automatic write_cfg(input logic [3:0] w);
        cfg_we    = 1'b1;
        cfg_wdata = w;
        cur_mode  = w[1:0];
        if (w[2]) begin
            model_inv = 1'b0;
        end
        if (w[3]) begin
            model_ovf = 1'b0;
        end
        @(negedge clk);
        cfg_we    = 1'b0;
        cfg_wdata = 4'b0000;
    endtask

    // Wait for all queued results and one more cycle for the flags
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else
            fail_run($sformatf("timeout in %s, %0d results never came out",
                     test_name, exp_q.size()));
        @(negedge clk);
        assert (out_count == in_count) else
            fail_run($sformatf("error %s: result count expected %0d actual %0d",
                     test_name, in_count, out_count));
    endtask

    task automatic check_flags();
        assert (flag_invalid == model_inv) else
            fail_run($sformatf("error %s: flag_invalid expected %b actual %b",
                     test_name, model_inv, flag_invalid));
        assert (flag_overflow == model_ovf) else
            fail_run($sformatf("error %s: flag_overflow expected %b actual %b",
                     test_name, model_ovf, flag_overflow));
    endtask

    // Result checker on the falling edge
    always @(negedge clk) begin : out_monitor
        exp_t e;
        if (rst_n && out_valid) begin
            assert (exp_q.size() != 0) else
                fail_run("out_valid came with no operation pending");
            e = exp_q.pop_front();
            assert (result == e.res) else
                fail_run($sformatf("error %s: expected %h actual %h",
                         test_name, e.res, result));
            model_inv = model_inv | e.invalid;
            model_ovf = model_ovf | e.overflow;
            out_count++;
        end
    end

    initial begin
        int sent;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        c         = '0;
        cfg_we    = 1'b0;
        cfg_wdata = 4'b0000;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Random exact stream with some idle cycles
        test_name = "random_exact";
        sent = 0;
        while (sent < 300) begin
            if (rand_bits(2) != 0) begin
                send_random();
                sent++;
            end else begin
                @(negedge clk);
            end
        end
        drain();
        check_flags();

        for (int m = 0; m < 4; m++) begin
            test_name = $sformatf("mode_%0d", m);
            write_cfg({2'b00, 2'(m)});
            repeat (50) send_random();
            drain();
            check_flags();
        end

        // ------------------------------------------------
        // Specials with the valid infinities first
        // ------------------------------------------------
        test_name = "special_inf";
        write_cfg(4'b0000);
        send(POS_INF, TWO, ONE);
        send(POS_INF, TWO, POS_INF);
        send(ONE, ONE, NEG_INF);
        send(NEG_INF, ONE, NEG_INF);
        drain();
        check_flags();
        test_name = "special_invalid";
        send(NAN_IN, ONE, ONE);
        send(POS_INF, 64'h0, ONE);
        send(POS_INF, ONE, NEG_INF);
        send(ONE, ONE, NAN_IN);
        drain();
        check_flags();

        // Zeros and exact cancellation
        test_name = "zero_cancel";
        send(64'h0, int_to_fp(1'b0, 5), NEG_ZERO);
        send(NEG_ZERO, int_to_fp(1'b1, 7), int_to_fp(1'b0, 9));
        send(int_to_fp(1'b0, 3), int_to_fp(1'b0, 4), int_to_fp(1'b1, 12));
        send(int_to_fp(1'b1, 3), int_to_fp(1'b0, 4), int_to_fp(1'b0, 12));
        drain();
        check_flags();

        // Overflow and then clearing of both flags
        test_name = "overflow";
        send(BIG, BIG, ONE);
        send(BIG | NEG_ZERO, BIG, 64'h0);
        drain();
        check_flags();
        test_name = "flag_clear";
        write_cfg(4'b1100);
        check_flags();
        repeat (40) send_random();
        drain();
        check_flags();

        if (out_count == in_count && exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run("result count mismatch at end of run");
        end
    end

endmodule

//--- fp_fma.f
+incdir+include
hw/fp_fma_pkg.sv
hw/fma_op_regs.sv
hw/fp_classify.sv
hw/fp_mul_norm.sv
hw/fp_align_add.sv
hw/fp_norm_pack.sv
hw/fp_fma_top.sv
testbench/fma_ref_pkg.sv
testbench/tb_fp_fma.sv
